// File: source/cache_geometry_pkg.sv
// L1 data cache geometry
package cache_geometry_pkg;

	// Address and word
	localparam int ADDR_W         = 32;
	localparam int WORD_W         = 32;
	localparam int BYTES_PER_WORD = 4;

	// Set and way organisation
	localparam int WAYS    = 4;
	localparam int WAY_W   = 2;
	localparam int SETS    = 16;
	localparam int INDEX_W = 4;                   // Address bits 9..6

	// Line layout
	localparam int OFFSET_W   = 6;                // Byte offset in a line
	localparam int WORD_SEL_W = 4;                // Address bits 5..2
	localparam int LINE_BYTES = 64;
	localparam int LINE_W     = LINE_BYTES * 8;   // 512 bits

	// Tag is whatever sits above index and offset
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;   // Address bits 31..10

	// Field positions inside an address
	localparam int WORD_LSB  = $clog2(BYTES_PER_WORD);
	localparam int INDEX_LSB = OFFSET_W;
	localparam int TAG_LSB   = OFFSET_W + INDEX_W;

endpackage

// File: source/cache_tag_pkg.sv
// L1 data cache tag entry
package cache_tag_pkg;

	// One tag RAM entry, valid bit on top
	typedef struct packed {
		logic                                  valid;
		logic [cache_geometry_pkg::TAG_W-1:0] tag;
	} tag_entry_t;

	// Valid bit value written on a fill
	localparam logic ENTRY_VALID = 1'b1;

	// Entry after reset or remove
	localparam tag_entry_t TAG_INVALID = '0;

endpackage

// File: source/cache_data_way.sv
// Cache data way RAM
`timescale 1ns/100ps

module cache_data_way (
	input  logic iCLOCK,
	input  logic wren,
	input  logic [cache_geometry_pkg::INDEX_W-1:0] wr_index,
	input  logic [cache_geometry_pkg::LINE_BYTES-1:0] byte_en,
	input  logic [cache_geometry_pkg::LINE_W-1:0] line_data,
	input  logic rd_en,                                        // Low holds rd_line
	input  logic [cache_geometry_pkg::INDEX_W-1:0] rd_index,
	output logic [cache_geometry_pkg::LINE_W-1:0] rd_line
);
	import cache_geometry_pkg::*;

	logic [LINE_W-1:0] mem [SETS];

	// Byte-enabled write
	always_ff @(posedge iCLOCK) begin
		if (wren) begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (byte_en[b]) begin
					mem[wr_index][b*8 +: 8] <= line_data[b*8 +: 8];
				end
			end
		end
	end

	// Registered read, old data on a same-edge write
	always_ff @(posedge iCLOCK) begin
		if (rd_en) begin
			rd_line <= mem[rd_index];
		end
	end

endmodule

// File: source/cache_tag_array.sv
// Cache tag array
`timescale 1ns/100ps

module cache_tag_array (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic iREMOVE,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iRD_ADDR,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iUP_ADDR,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iWR_ADDR,
	input  logic tag_fill,                                     // Fill accepted this cycle
	output logic rd_hit,
	output logic [cache_geometry_pkg::WAY_W-1:0] rd_way,
	output logic up_hit,
	output logic [cache_geometry_pkg::WAY_W-1:0] up_way,
	output logic [cache_geometry_pkg::WAY_W-1:0] fill_way
);
	import cache_geometry_pkg::*;
	import cache_tag_pkg::*;

	tag_entry_t tags [WAYS][SETS];

	logic [INDEX_W-1:0] rd_index;
	logic [INDEX_W-1:0] up_index;
	logic [INDEX_W-1:0] wr_index;
	logic [TAG_W-1:0]   wr_tag;
	logic               wr_hit;                                // Fill tag already present
	logic [WAY_W-1:0]   wr_way;
	logic [WAY_W-1:0]   free_way;

	// Hit flag and way, lowest matching valid way wins
	function automatic logic [WAY_W:0] lookup(input logic [TAG_W-1:0] tag,
			input logic [INDEX_W-1:0] index);
		logic [WAY_W:0] result;
		result = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (tags[w][index].valid && tags[w][index].tag == tag) begin
				result = {1'b1, WAY_W'(w)};
			end
		end
		return result;
	endfunction

	assign rd_index = iRD_ADDR[INDEX_LSB +: INDEX_W];
	assign up_index = iUP_ADDR[INDEX_LSB +: INDEX_W];
	assign wr_index = iWR_ADDR[INDEX_LSB +: INDEX_W];
	assign wr_tag   = iWR_ADDR[TAG_LSB +: TAG_W];

	always_comb begin
		{rd_hit, rd_way} = lookup(iRD_ADDR[TAG_LSB +: TAG_W], rd_index);
		{up_hit, up_way} = lookup(iUP_ADDR[TAG_LSB +: TAG_W], up_index);  // Own valid bit per way
		{wr_hit, wr_way} = lookup(wr_tag, wr_index);
	end

	// Victim when nothing matches
	always_comb begin
		free_way = WAY_W'(WAYS - 1);                           // Set full, replace way 3
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!tags[w][wr_index].valid) begin
				free_way = WAY_W'(w);                          // Lowest invalid way
			end
		end
	end

	assign fill_way = wr_hit ? wr_way : free_way;            // Refill in place on a match

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					tags[w][s] <= TAG_INVALID;
				end
			end
		end else if (iREMOVE) begin                            // Remove beats a fill
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					tags[w][s] <= TAG_INVALID;
				end
			end
		end else if (tag_fill) begin
			tags[fill_way][wr_index] <= '{valid: ENTRY_VALID, tag: wr_tag};
		end
	end

endmodule

// File: source/cache_line_write.sv
// Cache line write control
`timescale 1ns/100ps

module cache_line_write (
	input  logic iUP_REQ,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iUP_ADDR,
	input  logic [cache_geometry_pkg::BYTES_PER_WORD-1:0] iUP_MASK,
	input  logic [cache_geometry_pkg::WORD_W-1:0] iUP_DATA,
	input  logic iWR_REQ,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iWR_ADDR,
	input  logic [cache_geometry_pkg::LINE_W-1:0] iWR_DATA,
	input  logic up_hit,
	input  logic [cache_geometry_pkg::WAY_W-1:0] up_way,
	input  logic [cache_geometry_pkg::WAY_W-1:0] fill_way,
	output logic [cache_geometry_pkg::WAYS-1:0] way_wren,
	output logic [cache_geometry_pkg::INDEX_W-1:0] wr_index,
	output logic [cache_geometry_pkg::LINE_BYTES-1:0] byte_en,
	output logic [cache_geometry_pkg::LINE_W-1:0] line_data,
	output logic tag_fill,
	output logic oWR_BUSY,
	output logic oUP_BUSY
);
	import cache_geometry_pkg::*;

	logic [WORD_SEL_W-1:0] up_word;
	logic                  fill_go;                            // Fill not blocked by an upload

	assign up_word = iUP_ADDR[WORD_LSB +: WORD_SEL_W];
	assign fill_go = iWR_REQ && !iUP_REQ;

	// Upload owns the write port
	assign wr_index = iUP_REQ ? iUP_ADDR[INDEX_LSB +: INDEX_W] : iWR_ADDR[INDEX_LSB +: INDEX_W];

	// Mask lands on its word slot, fill writes every byte
	assign byte_en = iUP_REQ ?
		(LINE_BYTES'(iUP_MASK) << (up_word * BYTES_PER_WORD)) : {LINE_BYTES{1'b1}};

	assign line_data = iUP_REQ ? {(LINE_W / WORD_W){iUP_DATA}} : iWR_DATA;

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			if (iUP_REQ) begin
				way_wren[w] = up_hit && (up_way == WAY_W'(w));  // Miss writes nothing
			end else begin
				way_wren[w] = iWR_REQ && (fill_way == WAY_W'(w));
			end
		end
	end

	assign tag_fill = fill_go;   // Uploads leave the tag alone

	// Back-pressure, each side holds off the other
	assign oWR_BUSY = iUP_REQ;
	assign oUP_BUSY = iWR_REQ;

endmodule

// File: source/cache_read_out.sv
// Cache read result stage
`timescale 1ns/100ps

module cache_read_out (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic iREMOVE,
	input  logic iRD_REQ,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iRD_ADDR,
	input  logic iRD_BUSY,
	input  logic iWR_REQ,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iWR_ADDR,
	input  logic rd_hit,
	input  logic [cache_geometry_pkg::WAY_W-1:0] rd_way,
	input  logic [cache_geometry_pkg::LINE_W-1:0] way_lines [cache_geometry_pkg::WAYS],
	output logic rd_en,
	output logic [cache_geometry_pkg::INDEX_W-1:0] rd_index,
	output logic oRD_VALID,
	output logic oRD_HIT,
	output logic [cache_geometry_pkg::WORD_W-1:0] oRD_DATA,
	output logic oRD_BUSY
);
	import cache_geometry_pkg::*;

	logic                  b_req_valid;
	logic                  b_hit;
	logic [WAY_W-1:0]      b_way;
	logic [WORD_SEL_W-1:0] b_word;
	logic [LINE_W-1:0]     sel_line;

	// RAM output freezes with the buffer
	assign rd_en    = iRD_REQ && !iRD_BUSY;
	assign rd_index = iRD_ADDR[INDEX_LSB +: INDEX_W];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_req_valid <= 1'b0;
			b_hit       <= 1'b0;
			b_way       <= '0;
			b_word      <= '0;
		end else if (iREMOVE) begin
			b_req_valid <= 1'b0;                               // Drop the pending result
		end else if (!iRD_BUSY) begin
			b_req_valid <= iRD_REQ;
			b_hit       <= rd_hit;
			b_way       <= rd_way;
			b_word      <= iRD_ADDR[WORD_LSB +: WORD_SEL_W];
		end
	end

	assign sel_line = way_lines[b_way];

	// Outputs blank during a stall, result comes back after
	assign oRD_VALID = b_req_valid && !iRD_BUSY;
	assign oRD_HIT   = oRD_VALID && b_hit;
	assign oRD_DATA  = oRD_HIT ? sel_line[b_word*WORD_W +: WORD_W] : '0;

	// Read racing a fill of the same address
	assign oRD_BUSY = iRD_BUSY || (iRD_REQ && iWR_REQ && (iRD_ADDR == iWR_ADDR));

endmodule

// File: source/l1_data_cache.sv
// L1 data cache top level
`timescale 1ns/100ps

module l1_data_cache (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic iREMOVE,                                          // Invalidate every line
	// Read search
	input  logic iRD_REQ,
	output logic oRD_BUSY,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iRD_ADDR,
	output logic oRD_VALID,
	output logic oRD_HIT,
	input  logic iRD_BUSY,                                         // Downstream stall
	output logic [cache_geometry_pkg::WORD_W-1:0] oRD_DATA,
	// Store upload, write through
	input  logic iUP_REQ,
	output logic oUP_BUSY,
	input  logic [cache_geometry_pkg::BYTES_PER_WORD-1:0] iUP_MASK,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iUP_ADDR,
	input  logic [cache_geometry_pkg::WORD_W-1:0] iUP_DATA,
	// Line fill
	input  logic iWR_REQ,
	output logic oWR_BUSY,
	input  logic [cache_geometry_pkg::ADDR_W-1:0] iWR_ADDR,
	input  logic [cache_geometry_pkg::LINE_W-1:0] iWR_DATA
);

	// Lookup results
	logic                                    rd_hit;
	logic [cache_geometry_pkg::WAY_W-1:0]    rd_way;
	logic                                    up_hit;
	logic [cache_geometry_pkg::WAY_W-1:0]    up_way;
	logic [cache_geometry_pkg::WAY_W-1:0]    fill_way;
	logic                                    tag_fill;

	// Data way write side
	logic [cache_geometry_pkg::WAYS-1:0]       way_wren;
	logic [cache_geometry_pkg::INDEX_W-1:0]    wr_index;
	logic [cache_geometry_pkg::LINE_BYTES-1:0] byte_en;
	logic [cache_geometry_pkg::LINE_W-1:0]     line_data;

	// Data way read side
	logic                                      rd_en;
	logic [cache_geometry_pkg::INDEX_W-1:0]    rd_index;
	logic [cache_geometry_pkg::LINE_W-1:0]     way_lines [cache_geometry_pkg::WAYS];

	cache_tag_array u_tag_array (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.iREMOVE  (iREMOVE),
		.iRD_ADDR (iRD_ADDR),
		.iUP_ADDR (iUP_ADDR),
		.iWR_ADDR (iWR_ADDR),
		.tag_fill (tag_fill),
		.rd_hit   (rd_hit),
		.rd_way   (rd_way),
		.up_hit   (up_hit),
		.up_way   (up_way),
		.fill_way (fill_way)
	);

	cache_line_write u_line_write (
		.iUP_REQ   (iUP_REQ),
		.iUP_ADDR  (iUP_ADDR),
		.iUP_MASK  (iUP_MASK),
		.iUP_DATA  (iUP_DATA),
		.iWR_REQ   (iWR_REQ),
		.iWR_ADDR  (iWR_ADDR),
		.iWR_DATA  (iWR_DATA),
		.up_hit    (up_hit),
		.up_way    (up_way),
		.fill_way  (fill_way),
		.way_wren  (way_wren),
		.wr_index  (wr_index),
		.byte_en   (byte_en),
		.line_data (line_data),
		.tag_fill  (tag_fill),
		.oWR_BUSY  (oWR_BUSY),
		.oUP_BUSY  (oUP_BUSY)
	);

	// One RAM per way
	for (genvar g = 0; g < cache_geometry_pkg::WAYS; g++) begin : g_way
		cache_data_way u_data_way (
			.iCLOCK    (iCLOCK),
			.wren      (way_wren[g]),
			.wr_index  (wr_index),
			.byte_en   (byte_en),
			.line_data (line_data),
			.rd_en     (rd_en),
			.rd_index  (rd_index),
			.rd_line   (way_lines[g])
		);
	end

	cache_read_out u_read_out (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.iREMOVE   (iREMOVE),
		.iRD_REQ   (iRD_REQ),
		.iRD_ADDR  (iRD_ADDR),
		.iRD_BUSY  (iRD_BUSY),
		.iWR_REQ   (iWR_REQ),
		.iWR_ADDR  (iWR_ADDR),
		.rd_hit    (rd_hit),
		.rd_way    (rd_way),
		.way_lines (way_lines),
		.rd_en     (rd_en),
		.rd_index  (rd_index),
		.oRD_VALID (oRD_VALID),
		.oRD_HIT   (oRD_HIT),
		.oRD_DATA  (oRD_DATA),
		.oRD_BUSY  (oRD_BUSY)
	);

endmodule

// File: verif/l1_data_cache_checker.sv
// L1 data cache protocol checker
`timescale 1ns/100ps

module l1_data_cache_checker (
	input logic iCLOCK,
	input logic inRESET,
	input logic iREMOVE,
	input logic oRD_VALID,
	input logic oRD_HIT,
	input logic [cache_geometry_pkg::WORD_W-1:0] oRD_DATA,
	input logic iUP_REQ,
	input logic oWR_BUSY
);

	// A hit is always a valid result
	a_hit_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_HIT |-> oRD_VALID) else $error("read hit without read valid");

	a_miss_zero: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!oRD_HIT |-> (oRD_DATA == '0)) else $error("read data not zero without a hit");

	// Remove drops any pending result
	a_remove_clear: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		iREMOVE |=> !oRD_VALID) else $error("read valid after remove");

	a_wr_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oWR_BUSY == iUP_REQ) else $error("fill busy differs from upload request");

endmodule

// File: verif/l1_data_cache_tb.sv
// L1 data cache testbench
`timescale 1ns/100ps

module l1_data_cache_tb;
	import cache_geometry_pkg::*;

	logic iCLOCK, inRESET, iREMOVE;
	logic iRD_REQ, oRD_BUSY, oRD_VALID, oRD_HIT, iRD_BUSY;
	logic [ADDR_W-1:0] iRD_ADDR, iUP_ADDR, iWR_ADDR;
	logic [WORD_W-1:0] oRD_DATA, iUP_DATA;
	logic iUP_REQ, oUP_BUSY, iWR_REQ, oWR_BUSY;
	logic [BYTES_PER_WORD-1:0] iUP_MASK;
	logic [LINE_W-1:0] iWR_DATA;

	// Reference model state
	logic              m_valid [WAYS][SETS];
	logic [TAG_W-1:0]  m_tag   [WAYS][SETS];
	logic [LINE_W-1:0] m_line  [WAYS][SETS];

	logic [ADDR_W+WORD_W:0] exp_q [$];                         // {addr, hit, word}
	logic [ADDR_W+WORD_W:0] cur_exp;
	logic                   rd_pending;
	logic [15:0]            lfsr_state;
	logic [TAG_W-1:0]       base_tag [8];
	int checks, errors, test_num, test_err;

	l1_data_cache u_l1_data_cache (.*);

	bind l1_data_cache l1_data_cache_checker u_checker (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iREMOVE(iREMOVE), .oRD_VALID(oRD_VALID),
		.oRD_HIT(oRD_HIT), .oRD_DATA(oRD_DATA), .iUP_REQ(iUP_REQ), .oWR_BUSY(oWR_BUSY)
	);

	always #20 iCLOCK = ~iCLOCK;                               // 40 ns period

	// Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);                // One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [LINE_W-1:0] rand_line();
		logic [LINE_W-1:0] l;
		for (int i = 0; i < LINE_W / WORD_W; i++) begin
			l[i*WORD_W +: WORD_W] = rand_bits(32);
		end
		return l;
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
			input int set, input int word);
		return {tag, INDEX_W'(set), WORD_SEL_W'(word), 2'b00};
	endfunction

	// Expected {hit, word} from the model
	function automatic logic [WORD_W:0] expect_read(input logic [ADDR_W-1:0] addr);
		logic [WORD_W:0] res;
		res = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (m_valid[w][addr[9:6]] && m_tag[w][addr[9:6]] == addr[31:10])
				res = {1'b1, m_line[w][addr[9:6]][addr[5:2]*WORD_W +: WORD_W]};
		end
		return res;
	endfunction

	task automatic fill_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
		int way;
		way = WAYS - 1;                                        // Full set loses way 3
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!m_valid[w][addr[9:6]])
				way = w;
		end
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[w][addr[9:6]] && m_tag[w][addr[9:6]] == addr[31:10])
				way = w;
		end
		m_valid[way][addr[9:6]] = 1'b1;
		m_tag[way][addr[9:6]]   = addr[31:10];
		m_line[way][addr[9:6]]  = line;
		iWR_REQ  = 1'b1;
		iWR_ADDR = addr;
		iWR_DATA = line;
		@(negedge iCLOCK);
		iWR_REQ = 1'b0;
	endtask

	task automatic upload_word(input logic [ADDR_W-1:0] addr, input logic [3:0] mask,
			input logic [WORD_W-1:0] data);
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[w][addr[9:6]] && m_tag[w][addr[9:6]] == addr[31:10]) begin
				for (int b = 0; b < BYTES_PER_WORD; b++) begin
					if (mask[b])
						m_line[w][addr[9:6]][addr[5:2]*WORD_W + b*8 +: 8] = data[b*8 +: 8];
				end
			end
		end
		iUP_REQ  = 1'b1;
		iUP_ADDR = addr;
		iUP_MASK = mask;
		iUP_DATA = data;
		@(negedge iCLOCK);
		iUP_REQ = 1'b0;
	endtask

	task automatic read_addr(input logic [ADDR_W-1:0] addr);
		exp_q.push_back({addr, expect_read(addr)});
		iRD_REQ  = 1'b1;
		iRD_ADDR = addr;
		@(negedge iCLOCK);
		iRD_REQ = 1'b0;
	endtask

	// Drain pending reads, then report the test
	task automatic end_test(input string name);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || rd_pending) && n < 50) begin
			@(negedge iCLOCK);
			n++;
		end
		if (exp_q.size() != 0 || rd_pending) begin
			$display("timeout: read results of test %0d never arrived", test_num);
			$display("Test failed");
			$finish;
		end
		$display("test %0d %s: %s", test_num, name, (errors == test_err) ? "ok" : "errors");
		test_num++;
		test_err = errors;
	endtask

	// Compare process, outputs sampled before this edge updates them
	always @(posedge iCLOCK) begin
		if (rd_pending && iRD_BUSY) begin
			checks++;
			if (oRD_VALID !== 1'b0 || oRD_HIT !== 1'b0 || oRD_DATA !== '0 ||
					oRD_BUSY !== 1'b1) begin
				errors++;
				$display("mismatch stall valid/hit/data/busy: got %h %h %h %h expected 0 0 0 1",
					oRD_VALID, oRD_HIT, oRD_DATA, oRD_BUSY);
			end
		end else if (rd_pending) begin
			rd_pending = 1'b0;
			if (exp_q.size() == 0) begin
				errors++;
				$display("read result arrived with no request on record");
			end else begin
				cur_exp = exp_q.pop_front();
				checks++;
				if (oRD_VALID !== 1'b1) begin
					errors++;
					$display("mismatch oRD_VALID addr %h: got %h expected 1",
						cur_exp[64:33], oRD_VALID);
				end
				if (oRD_HIT !== cur_exp[32]) begin
					errors++;
					$display("mismatch oRD_HIT addr %h: got %h expected %h",
						cur_exp[64:33], oRD_HIT, cur_exp[32]);
				end
				if (oRD_DATA !== cur_exp[31:0]) begin
					errors++;
					$display("mismatch oRD_DATA addr %h: got %h expected %h",
						cur_exp[64:33], oRD_DATA, cur_exp[31:0]);
				end
			end
		end
		if (inRESET && iRD_REQ && !iRD_BUSY)
			rd_pending = 1'b1;                                 // Result due next edge
	end

	initial begin
		logic [31:0] r;
		logic [ADDR_W-1:0] a;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		iREMOVE = 1'b0;
		iRD_REQ = 1'b0;
		iRD_ADDR = '0;
		iRD_BUSY = 1'b0;
		iUP_REQ = 1'b0;
		iUP_MASK = '0;
		iUP_ADDR = '0;
		iUP_DATA = '0;
		iWR_REQ = 1'b0;
		iWR_ADDR = '0;
		iWR_DATA = '0;
		rd_pending = 1'b0;
		lfsr_state = 16'd45514;
		checks = 0;
		errors = 0;
		test_num = 1;
		test_err = 0;
		for (int w = 0; w < WAYS; w++) begin
			for (int s = 0; s < SETS; s++) begin
				m_valid[w][s] = 1'b0;
			end
		end
		repeat (10) @(negedge iCLOCK);
		inRESET = 1'b1;

		for (int s = 0; s < 6; s++) begin                      // Random lines, sets 0..5
			r = rand_bits(TAG_W);
			base_tag[s] = r[TAG_W-1:0];
			fill_line(make_addr(base_tag[s], s, 0), rand_line());
		end
		for (int s = 0; s < 6; s++) begin
			for (int i = 0; i < 16; i++) begin
				read_addr(make_addr(base_tag[s], s, i));
			end
		end
		end_test("fill and read back");

		for (int s = 0; s < 10; s++) begin
			read_addr(make_addr(base_tag[s % 6] ^ TAG_W'(s + 1), s, s));
		end
		end_test("read miss");

		for (int s = 0; s < 6; s++) begin
			r = rand_bits(4);
			upload_word(make_addr(base_tag[s], s, s + 3), r[3:0], rand_bits(32));
			upload_word(make_addr(base_tag[s] ^ TAG_W'(2), s, 1), 4'hf, rand_bits(32));
		end
		for (int s = 0; s < 6; s++) begin
			read_addr(make_addr(base_tag[s], s, s + 3));
			read_addr(make_addr(base_tag[s] ^ TAG_W'(2), s, 1));
		end
		end_test("masked upload");

		r = rand_bits(TAG_W);
		base_tag[6] = r[TAG_W-1:0];
		for (int t = 0; t < 5; t++) begin
			fill_line(make_addr(base_tag[6] + TAG_W'(t), 12, 0), rand_line());
		end
		for (int t = 0; t < 5; t++) begin
			read_addr(make_addr(base_tag[6] + TAG_W'(t), 12, t));
		end
		end_test("replacement");

		a = make_addr(base_tag[0], 13, 7);
		fill_line(a, rand_line());
		exp_q.push_back({a, expect_read(a)});
		iRD_REQ = 1'b1;
		iRD_ADDR = a;
		@(negedge iCLOCK);
		iRD_REQ = 1'b0;
		iRD_BUSY = 1'b1;                                       // Stall the held result
		repeat (3) @(negedge iCLOCK);
		iRD_BUSY = 1'b0;
		end_test("read stall");

		a = make_addr(base_tag[1], 14, 0);
		upload_word(make_addr(base_tag[2], 14, 2), 4'hf, 32'h0);  // Pair fill with upload
		exp_q.push_back({a, expect_read(a)});                  // Read racing the fill
		iWR_REQ = 1'b1;
		iUP_REQ = 1'b1;
		iRD_REQ = 1'b1;
		iRD_ADDR = a;
		iWR_ADDR = a;
		iWR_DATA = rand_line();
		iUP_ADDR = make_addr(base_tag[2], 14, 2);
		@(posedge iCLOCK);
		checks++;
		if (oWR_BUSY !== 1'b1 || oUP_BUSY !== 1'b1 || oRD_BUSY !== 1'b1) begin
			errors++;
			$display("mismatch oWR_BUSY/oUP_BUSY/oRD_BUSY: got %h %h %h expected 1 1 1",
				oWR_BUSY, oUP_BUSY, oRD_BUSY);
		end
		@(negedge iCLOCK);
		iWR_REQ = 1'b0;
		iUP_REQ = 1'b0;
		iRD_REQ = 1'b0;
		read_addr(a);                                          // Blocked fill left no line
		end_test("fill blocked by upload");

		iREMOVE = 1'b1;
		for (int w = 0; w < WAYS; w++) begin
			for (int s = 0; s < SETS; s++) begin
				m_valid[w][s] = 1'b0;
			end
		end
		@(negedge iCLOCK);
		iREMOVE = 1'b0;
		for (int s = 0; s < 6; s++) begin
			read_addr(make_addr(base_tag[s], s, 0));
		end
		for (int t = 0; t < 5; t++) begin
			read_addr(make_addr(base_tag[6] + TAG_W'(t), 12, 0));
		end
		read_addr(make_addr(base_tag[0], 13, 7));
		end_test("remove");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: sim.f
source/cache_geometry_pkg.sv
source/cache_tag_pkg.sv
source/cache_data_way.sv
source/cache_tag_array.sv
source/cache_line_write.sv
source/cache_read_out.sv
source/l1_data_cache.sv
verif/l1_data_cache_checker.sv
verif/l1_data_cache_tb.sv

// File: Makefile
# Verilator build and run for the L1 data cache testbench

VERILATOR ?= verilator
TOP       ?= l1_data_cache_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
